/* Bender.yml */
package:
  name: fetch_unit

sources:
  # packages first, then leaf modules, then the top level
  - files:
      - hw/axi_pkg.sv
      - hw/fetch_pkg.sv
      - hw/fetch_csr.sv
      - hw/fetch_sequencer.sv
      - hw/axi_fetch_bridge.sv
      - hw/fetch_unit_top.sv

  - target: test
    files:
      - bench/fetch_unit_asserts.sv
      - bench/fetch_unit_tb.sv

/* bench/fetch_unit_asserts.sv */
`timescale 1ns/10ps

module fetch_unit_asserts
    import fetch_pkg::*;
    import axi_pkg::*;
(
    input logic          clock,
    input logic          reset,
    input logic          stall_i,
    input logic          instr_valid_i,
    input addr_t         pc_i,
    input logic          rw_ready_i,         // bridge answer to the sequencer
    input bridge_state_e br_state_i,
    input logic          axi_ar_valid_i,
    input axi_ar_t       axi_ar_i,
    input logic          axi_ar_ready_i,
    input logic          axi_r_valid_i,
    input logic          axi_r_ready_i
);

    int unsigned fail_count = 0;               // failures so far, sampled by the testbench

    // AR valid and payload hold until the slave takes them
    ar_stable: assert property (@(posedge clock) disable iff (!reset)
        axi_ar_valid_i && !axi_ar_ready_i |=> axi_ar_valid_i && $stable(axi_ar_i))
        else begin
            $error("AR valid or payload changed before ready");
            fail_count++;
        end

    // R ready only once the address is gone
    r_after_ar: assert property (@(posedge clock) disable iff (!reset)
        !(axi_r_ready_i && axi_ar_valid_i))
        else begin
            $error("R ready raised while AR valid still pending");
            fail_count++;
        end

    // decode back-pressure blocks delivery
    no_valid_in_stall: assert property (@(posedge clock) disable iff (!reset)
        !(instr_valid_i && stall_i))
        else begin
            $error("instruction delivered during stall");
            fail_count++;
        end

    // every delivery steps the pc by one instruction
    pc_step: assert property (@(posedge clock) disable iff (!reset)
        instr_valid_i |=> pc_i == $past(pc_i) + INSTR_BYTES)
        else begin
            $error("pc did not advance by 4 after a delivery");
            fail_count++;
        end

    // ready comes up one cycle after the beat lands
    ready_after_beat: assert property (@(posedge clock) disable iff (!reset)
        $rose(rw_ready_i) |->
            $past(br_state_i == BR_R_WAIT && axi_r_valid_i && axi_r_ready_i))
        else begin
            $error("bridge ready rose without a beat returned the cycle before");
            fail_count++;
        end

endmodule

bind fetch_unit_top fetch_unit_asserts fetch_unit_asserts_inst (
    .clock          (clock),
    .reset          (reset),
    .stall_i        (stall_i),
    .instr_valid_i  (instr_valid_o),
    .pc_i           (pc_o),
    .rw_ready_i     (rw_ready),
    .br_state_i     (axi_fetch_bridge_inst.state_q),
    .axi_ar_valid_i (axi_ar_valid_o),
    .axi_ar_i       (axi_ar_o),
    .axi_ar_ready_i (axi_ar_ready_i),
    .axi_r_valid_i  (axi_r_valid_i),
    .axi_r_ready_i  (axi_r_ready_o)
);

/* bench/fetch_unit_tb.sv */
`timescale 1ns/10ps

module fetch_unit_tb
    import fetch_pkg::*;
    import axi_pkg::*;
();

    localparam int SEQ_LEN = 16;                    // deliveries per sequential run
    // ~40 deliveries, worst beat about 2*(3+2) cycles, plus idle gaps, with margin
    localparam int WATCHDOG_CYCLES = 2000;

    logic      clock = 1'b0;
    logic      reset;
    logic      csr_we_i;
    csr_addr_t csr_addr_i;
    xlen_t     csr_wdata_i;
    xlen_t     csr_rdata_o;
    logic      stall_i;
    logic      instr_valid_o;
    instr_t    instr_o;
    addr_t     pc_o;
    logic      axi_ar_valid_o;
    axi_ar_t   axi_ar_o;
    logic      axi_ar_ready_i;
    logic      axi_r_valid_i;
    axi_r_t    axi_r_i;
    logic      axi_r_ready_o;

    logic [31:0] lcg_state = 32'hfb632953;
    logic [1:0]  ar_wait;                            // slave wait states left
    logic [1:0]  r_wait;
    logic        r_pending;                          // AR taken, beat owed
    addr_t       r_addr;
    int unsigned ar_count = 0;                       // AR transfers seen
    int unsigned valid_cycles = 0;                   // instr_valid_o cycles seen

    string       test_name = "init";
    int unsigned errors = 0;
    int unsigned err_base;
    int unsigned assert_base;
    int unsigned tests_run = 0;
    int unsigned tests_failed = 0;

    fetch_unit_top fetch_unit_top_inst (
        .clock          (clock),
        .reset          (reset),
        .csr_we_i       (csr_we_i),
        .csr_addr_i     (csr_addr_i),
        .csr_wdata_i    (csr_wdata_i),
        .csr_rdata_o    (csr_rdata_o),
        .stall_i        (stall_i),
        .instr_valid_o  (instr_valid_o),
        .instr_o        (instr_o),
        .pc_o           (pc_o),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_o       (axi_ar_o),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_i        (axi_r_i),
        .axi_r_ready_o  (axi_r_ready_o)
    );

    always #4 clock = ~clock;                        // 8 ns period

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [1:0] rand_delay();
        logic [31:0] v;
        v = lcg_next();
        return v[17:16];                             // upper bits, 0..3
    endfunction

    // memory image, each 32-bit word derived from its byte address
    function automatic instr_t mem_word(addr_t a);
        return a[31:0] ^ 32'h5a5a_0000;
    endfunction

    // single 8-byte beat, aligned, fixed attributes
    function automatic axi_ar_t single_beat_ar(addr_t a);
        axi_ar_t ar;
        ar       = '0;                               // len 0, id and user zero
        ar.addr  = {a[63:3], 3'b000};
        ar.prot  = AXI_PROT_DATA_UNPRIV_SECURE;
        ar.size  = AXI_SIZE_BEAT;
        ar.burst = AXI_BURST_INCR;
        ar.cache = AXI_CACHE_NONCACHE_NONBUF;
        return ar;
    endfunction

    function automatic int unsigned assert_failures();
        return fetch_unit_top_inst.fetch_unit_asserts_inst.fail_count;
    endfunction

    // AXI slave, random wait states on AR and R
    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            axi_ar_ready_i <= 1'b0;
            axi_r_valid_i  <= 1'b0;
            axi_r_i        <= '0;
            r_pending      <= 1'b0;
            r_addr         <= '0;
            ar_wait        <= rand_delay();
            r_wait         <= rand_delay();
        end else begin
            if (axi_ar_valid_o && axi_ar_ready_i) begin
                assert (axi_ar_o == single_beat_ar(axi_ar_o.addr)) else begin
                    $display("[FAIL] %s ar payload: expected %h actual %h",
                             test_name, single_beat_ar(axi_ar_o.addr), axi_ar_o);
                    errors++;
                end
                axi_ar_ready_i <= 1'b0;
                ar_wait        <= rand_delay();
                ar_count       <= ar_count + 1;
                r_pending      <= 1'b1;
                r_addr         <= axi_ar_o.addr;
            end else if (axi_ar_valid_o) begin
                if (ar_wait == 2'd0) begin
                    axi_ar_ready_i <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end
            if (axi_r_valid_i && axi_r_ready_o) begin
                axi_r_valid_i <= 1'b0;
                r_pending     <= 1'b0;
                r_wait        <= rand_delay();
            end else if (r_pending && !axi_r_valid_i) begin
                if (r_wait == 2'd0) begin
                    axi_r_valid_i <= 1'b1;
                    axi_r_i.data  <= {mem_word(r_addr + addr_t'(4)), mem_word(r_addr)};
                    axi_r_i.last  <= 1'b1;           // always single beat
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
        end
    end

    // every delivered word must match memory at pc_o
    always @(posedge clock) begin
        if (reset && instr_valid_o) begin
            valid_cycles <= valid_cycles + 1;
            assert (instr_o == mem_word(pc_o)) else begin
                $display("[FAIL] %s instr at pc %h: expected %h actual %h",
                         test_name, pc_o, mem_word(pc_o), instr_o);
                errors++;
            end
        end
    end

    task automatic compare_value(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s %s: expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic csr_write(input csr_addr_t a, input xlen_t d);
        @(posedge clock);
        csr_we_i    <= 1'b1;
        csr_addr_i  <= a;
        csr_wdata_i <= d;
        @(posedge clock);
        csr_we_i    <= 1'b0;
    endtask

    task automatic csr_read(input csr_addr_t a, output xlen_t d);
        @(posedge clock);
        csr_addr_i <= a;
        @(posedge clock);
        d = csr_rdata_o;                             // read path is combinational
    endtask

    task automatic next_delivery(output addr_t pc, output instr_t ins);
        do begin
            @(posedge clock);
        end while (!instr_valid_o);
        pc  = pc_o;
        ins = instr_o;
    endtask

    // let an in-flight read drain after fetch is switched off
    task automatic wait_bus_idle();
        repeat (2) @(posedge clock);
        while (axi_ar_valid_o || axi_r_ready_o || r_pending) begin
            @(posedge clock);
        end
        repeat (2) @(posedge clock);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        err_base    = errors;
        assert_base = assert_failures();
    endtask

    task automatic end_test();
        int unsigned n;
        n = (errors - err_base) + (assert_failures() - assert_base);
        tests_run++;
        if (n == 0) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, n);
        end
    endtask

    initial begin
        addr_t       pc;
        addr_t       prev_pc;
        instr_t      ins;
        xlen_t       rd;
        int unsigned ar_base;
        int          i;

        reset          <= 1'b0;
        csr_we_i       <= 1'b0;
        csr_addr_i     <= CSR_BOOT;
        csr_wdata_i    <= '0;
        stall_i        <= 1'b0;
        axi_ar_ready_i <= 1'b0;
        axi_r_valid_i  <= 1'b0;
        axi_r_i        <= '0;
        repeat (5) @(posedge clock);
        reset <= 1'b1;

        start_test("reset_disable");                 // quiet bus until enable
        repeat (20) begin
            @(posedge clock);
            compare_value("ar_valid", 0, axi_ar_valid_o);
            compare_value("r_ready", 0, axi_r_ready_o);
            compare_value("instr_valid", 0, instr_valid_o);
        end
        compare_value("ar transfers", 0, ar_count);
        end_test();

        start_test("boot");
        csr_write(CSR_BOOT, 64'h1000);
        csr_write(CSR_CTRL, 64'd1);
        next_delivery(pc, ins);
        compare_value("first pc", 64'h1000, pc);
        end_test();

        start_test("sequential");
        prev_pc = pc;
        for (i = 1; i < SEQ_LEN; i++) begin
            next_delivery(pc, ins);
            compare_value("pc step", prev_pc + INSTR_BYTES, pc);
            compare_value("instr", mem_word(pc), ins);
            prev_pc = pc;
        end
        end_test();

        start_test("beat_reuse");                    // restart from an aligned boot address
        csr_write(CSR_CTRL, 64'd0);
        wait_bus_idle();
        csr_write(CSR_BOOT, 64'h2000);
        ar_base = ar_count;
        csr_write(CSR_CTRL, 64'd1);
        for (i = 0; i < SEQ_LEN; i++) begin
            next_delivery(pc, ins);
            compare_value("pc", 64'h2000 + addr_t'(i) * INSTR_BYTES, pc);
        end
        compare_value("ar transfers", SEQ_LEN / 2, ar_count - ar_base);
        end_test();

        start_test("redirect");                      // odd word, high half of the beat
        csr_write(CSR_REDIRECT, 64'h3004);
        next_delivery(pc, ins);
        compare_value("target pc", 64'h3004, pc);
        compare_value("target instr", mem_word(64'h3004), ins);
        next_delivery(pc, ins);
        compare_value("pc after target", 64'h3008, pc);
        end_test();

        start_test("stall_count");
        @(posedge clock);
        stall_i <= 1'b1;
        @(posedge clock);
        prev_pc = pc_o;
        repeat (12) begin
            @(posedge clock);
            compare_value("instr_valid under stall", 0, instr_valid_o);
            compare_value("pc under stall", prev_pc, pc_o);
        end
        csr_read(CSR_COUNT, rd);
        compare_value("count under stall", valid_cycles, rd);
        stall_i <= 1'b0;
        for (i = 0; i < 4; i++) begin
            next_delivery(pc, ins);
        end
        csr_read(CSR_COUNT, rd);
        compare_value("count running", valid_cycles, rd);
        end_test();

        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, assert_failures());
        if (tests_failed == 0 && errors == 0 && assert_failures() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles, test %s never finished",
                 WATCHDOG_CYCLES, test_name);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* fetch_unit.f */
hw/axi_pkg.sv
hw/fetch_pkg.sv
hw/fetch_csr.sv
hw/fetch_sequencer.sv
hw/axi_fetch_bridge.sv
hw/fetch_unit_top.sv
bench/fetch_unit_asserts.sv
bench/fetch_unit_tb.sv

/* hw/axi_fetch_bridge.sv */
`timescale 1ns/10ps

module axi_fetch_bridge
    import fetch_pkg::*;
    import axi_pkg::*;
(
    input  logic    clock,
    input  logic    reset,

    // sequencer side, plain levels
    input  logic    rw_valid_i,
    input  addr_t   rw_addr_i,
    output logic    rw_ready_o,
    output xlen_t   beat_data_o,

    // AXI read master
    output logic    axi_ar_valid_o,
    output axi_ar_t axi_ar_o,
    input  logic    axi_ar_ready_i,
    input  logic    axi_r_valid_i,
    input  axi_r_t  axi_r_i,
    output logic    axi_r_ready_o
);

    bridge_state_e state_q, state_d;

    addr_t addr_q;                      // address of the beat in flight or held
    xlen_t data_q;                      // last returned beat

    logic ar_fire;
    logic r_fire;
    logic addr_hit;
    logic load_addr;                    // capture rw_addr_i on entry to BR_AR_WAIT

    assign ar_fire  = axi_ar_valid_o && axi_ar_ready_i;
    assign r_fire   = axi_r_valid_i && axi_r_ready_o;
    assign addr_hit = (rw_addr_i == addr_q);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= BR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // next state
    always_comb begin
        state_d   = state_q;
        load_addr = 1'b0;
        unique case (state_q)
            BR_IDLE: begin
                if (rw_valid_i) begin
                    state_d   = BR_AR_WAIT;
                    load_addr = 1'b1;
                end
            end
            BR_AR_WAIT: begin
                // valid must stay up until accepted, whatever the sequencer does
                if (ar_fire) begin
                    state_d = BR_R_WAIT;
                end
            end
            BR_R_WAIT: begin
                if (r_fire) begin
                    state_d = BR_HOLD;
                end
            end
            BR_HOLD: begin
                if (!rw_valid_i) begin
                    state_d = BR_IDLE;
                end else if (!addr_hit) begin
                    state_d   = BR_AR_WAIT;    // new beat needed
                    load_addr = 1'b1;
                end
            end
            default: state_d = BR_IDLE;
        endcase
    end

    // address register, AR payload comes from here so it cannot move mid handshake
    always_ff @(posedge clock) begin
        if (load_addr) begin
            addr_q <= rw_addr_i;
        end
    end

    // beat capture, resp is not looked at
    always_ff @(posedge clock) begin
        if (r_fire) begin
            data_q <= axi_r_i.data;
        end
    end

    // channel controls straight from the state
    assign axi_ar_valid_o = (state_q == BR_AR_WAIT);
    assign axi_r_ready_o  = (state_q == BR_R_WAIT);    // only after the AR transfer

    // held beat is good only for the address it was fetched for
    assign rw_ready_o  = (state_q == BR_HOLD) && rw_valid_i && addr_hit;
    assign beat_data_o = data_q;

    // fixed single-beat read
    always_comb begin
        axi_ar_o        = '0;
        axi_ar_o.addr   = addr_q;
        axi_ar_o.prot   = AXI_PROT_DATA_UNPRIV_SECURE;
        axi_ar_o.id     = '0;
        axi_ar_o.user   = '0;
        axi_ar_o.len    = '0;                  // one beat
        axi_ar_o.size   = AXI_SIZE_BEAT;
        axi_ar_o.burst  = AXI_BURST_INCR;
        axi_ar_o.lock   = 1'b0;
        axi_ar_o.cache  = AXI_CACHE_NONCACHE_NONBUF;
        axi_ar_o.qos    = '0;
        axi_ar_o.region = '0;
    end

endmodule

/* hw/axi_pkg.sv */
package axi_pkg;

    // bus geometry of the fetch port
    localparam int AXI_ADDR_W = 64;
    localparam int AXI_DATA_W = 64;                 // one beat = one 64-bit word

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [3:0]            axi_id_t;
    typedef logic [0:0]            axi_user_t;
    typedef logic [7:0]            axi_len_t;       // beats minus one
    typedef logic [2:0]            axi_size_t;      // log2 of bytes per beat
    typedef logic [1:0]            axi_burst_t;
    typedef logic [3:0]            axi_cache_t;
    typedef logic [2:0]            axi_prot_t;
    typedef logic [1:0]            axi_resp_t;

    // read address channel payload
    typedef struct packed {
        axi_addr_t  addr;
        axi_prot_t  prot;
        axi_id_t    id;
        axi_user_t  user;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
        logic       lock;
        axi_cache_t cache;
        logic [3:0] qos;
        logic [3:0] region;
    } axi_ar_t;

    // read data channel payload
    typedef struct packed {
        axi_data_t data;
        axi_resp_t resp;                            // carried, not checked
        logic      last;
        axi_id_t   id;
        axi_user_t user;
    } axi_r_t;

    // encodings driven by the fetch master
    localparam axi_prot_t  AXI_PROT_DATA_UNPRIV_SECURE = 3'b000;   // data, unpriv, secure
    localparam axi_burst_t AXI_BURST_INCR              = 2'b01;
    localparam axi_cache_t AXI_CACHE_NONCACHE_NONBUF   = 4'b0010;  // normal memory
    localparam axi_size_t  AXI_SIZE_BEAT               = 3'd3;     // 8 bytes

endpackage

/* hw/fetch_csr.sv */
`timescale 1ns/10ps

module fetch_csr
    import fetch_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      csr_we_i,
    input  csr_addr_t csr_addr_i,
    input  xlen_t     csr_wdata_i,
    output xlen_t     csr_rdata_o,
    input  logic      deliver_i,            // one pulse per instruction handed out
    output logic      fetch_en_o,
    output addr_t     boot_addr_o,
    output logic      redirect_o,
    output addr_t     redirect_addr_o
);

    addr_t boot_q;
    logic  en_q;
    logic  redirect_q;
    addr_t target_q;
    xlen_t count_q;

    logic wr_boot, wr_ctrl, wr_redirect, wr_count;

    // write decode
    assign wr_boot     = csr_we_i && (csr_addr_i == CSR_BOOT);
    assign wr_ctrl     = csr_we_i && (csr_addr_i == CSR_CTRL);
    assign wr_redirect = csr_we_i && (csr_addr_i == CSR_REDIRECT);
    assign wr_count    = csr_we_i && (csr_addr_i == CSR_COUNT);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            boot_q     <= BOOT_RESET;
            en_q       <= 1'b0;                  // no bus traffic until software enables
            redirect_q <= 1'b0;
            count_q    <= '0;
        end else begin
            redirect_q <= wr_redirect;           // single cycle strobe
            if (wr_boot) begin
                boot_q <= csr_wdata_i;
            end
            if (wr_ctrl) begin
                en_q <= csr_wdata_i[0];
            end
            // a write clears, otherwise count deliveries
            if (wr_count) begin
                count_q <= '0;
            end else if (deliver_i) begin
                count_q <= count_q + xlen_t'(1);
            end
        end
    end

    // jump target, only meaningful with the strobe
    always_ff @(posedge clock) begin
        if (wr_redirect) begin
            target_q <= csr_wdata_i;
        end
    end

    // read mux, straight from the offset
    always_comb begin
        csr_rdata_o = '0;
        unique case (csr_addr_i)
            CSR_BOOT:     csr_rdata_o = boot_q;
            CSR_CTRL:     csr_rdata_o = {63'd0, en_q};
            CSR_REDIRECT: csr_rdata_o = target_q;
            CSR_COUNT:    csr_rdata_o = count_q;
            default:      csr_rdata_o = '0;
        endcase
    end

    assign fetch_en_o      = en_q;
    assign boot_addr_o     = boot_q;
    assign redirect_o      = redirect_q;
    assign redirect_addr_o = target_q;

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

    // core word widths
    typedef logic [63:0] xlen_t;                    // data word, one AXI beat
    typedef logic [63:0] addr_t;                    // fetch address
    typedef logic [31:0] instr_t;                   // one instruction

    // register block offsets
    typedef logic [1:0] csr_addr_t;

    localparam csr_addr_t CSR_BOOT     = 2'd0;      // boot address
    localparam csr_addr_t CSR_CTRL     = 2'd1;      // bit 0 = fetch enable
    localparam csr_addr_t CSR_REDIRECT = 2'd2;      // write = jump
    localparam csr_addr_t CSR_COUNT    = 2'd3;      // delivered instructions

    // reset value of the boot register
    localparam addr_t BOOT_RESET = 64'h0000_0000_8000_0000;

    // pc step and beat size in bytes
    localparam addr_t INSTR_BYTES = 64'd4;
    localparam addr_t BEAT_BYTES  = 64'd8;

    // bridge read machine
    // gray-ish order, only one bit flips per normal step
    typedef enum logic [1:0] {
        BR_IDLE    = 2'b00,                         // no request
        BR_AR_WAIT = 2'b01,                         // address out, waiting for ready
        BR_R_WAIT  = 2'b11,                         // waiting for the beat
        BR_HOLD    = 2'b10                          // beat held, served while addr matches
    } bridge_state_e;

endpackage

/* hw/fetch_sequencer.sv */
`timescale 1ns/10ps

module fetch_sequencer
    import fetch_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   fetch_en_i,
    input  addr_t  boot_addr_i,
    input  logic   redirect_i,
    input  addr_t  redirect_addr_i,
    input  logic   stall_i,             // decode back-pressure
    output logic   rw_valid_o,
    output addr_t  rw_addr_o,
    input  logic   rw_ready_i,
    input  xlen_t  beat_data_i,
    output logic   instr_valid_o,
    output instr_t instr_o,
    output addr_t  pc_o,
    output logic   deliver_o
);

    addr_t pc_q;
    logic  fetch_en_q;                  // enable seen last cycle
    logic  boot_load;

    // rising edge of enable restarts at the boot address
    assign boot_load = fetch_en_i && !fetch_en_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            fetch_en_q <= 1'b0;
            pc_q       <= BOOT_RESET;
        end else begin
            fetch_en_q <= fetch_en_i;
            if (boot_load) begin
                pc_q <= boot_addr_i;
            end else if (redirect_i) begin
                pc_q <= redirect_addr_i;          // wins over a pending step
            end else if (instr_valid_o) begin
                pc_q <= pc_q + INSTR_BYTES;
            end
        end
    end

    // request only once the pc holds the boot address
    // stays up under stall, the held beat waits in the bridge
    assign rw_valid_o = fetch_en_i && fetch_en_q;
    assign rw_addr_o  = pc_q & ~(BEAT_BYTES - addr_t'(1));   // beat aligned

    // a redirect kills the old instruction in the same cycle
    assign instr_valid_o = rw_ready_i && fetch_en_i && !stall_i && !redirect_i;

    // bit 2 picks the word within the beat
    assign instr_o = pc_q[2] ? beat_data_i[63:32] : beat_data_i[31:0];

    assign pc_o      = pc_q;
    assign deliver_o = instr_valid_o;   // counted by the register block

endmodule

/* hw/fetch_unit_top.sv */
`timescale 1ns/10ps

module fetch_unit_top
    import fetch_pkg::*;
    import axi_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    // register port
    input  logic      csr_we_i,
    input  csr_addr_t csr_addr_i,
    input  xlen_t     csr_wdata_i,
    output xlen_t     csr_rdata_o,

    // decode side
    input  logic      stall_i,
    output logic      instr_valid_o,
    output instr_t    instr_o,
    output addr_t     pc_o,

    // AXI read master
    output logic      axi_ar_valid_o,
    output axi_ar_t   axi_ar_o,
    input  logic      axi_ar_ready_i,
    input  logic      axi_r_valid_i,
    input  axi_r_t    axi_r_i,
    output logic      axi_r_ready_o
);

    // register block to sequencer
    logic  fetch_en;
    addr_t boot_addr;
    logic  redirect;
    addr_t redirect_addr;
    logic  deliver;             // back to the counter

    // sequencer to bridge
    logic  rw_valid;
    addr_t rw_addr;
    logic  rw_ready;
    xlen_t beat_data;

    fetch_csr fetch_csr_inst (
        .clock           (clock),
        .reset           (reset),
        .csr_we_i        (csr_we_i),
        .csr_addr_i      (csr_addr_i),
        .csr_wdata_i     (csr_wdata_i),
        .csr_rdata_o     (csr_rdata_o),
        .deliver_i       (deliver),
        .fetch_en_o      (fetch_en),
        .boot_addr_o     (boot_addr),
        .redirect_o      (redirect),
        .redirect_addr_o (redirect_addr)
    );

    fetch_sequencer fetch_sequencer_inst (
        .clock           (clock),
        .reset           (reset),
        .fetch_en_i      (fetch_en),
        .boot_addr_i     (boot_addr),
        .redirect_i      (redirect),
        .redirect_addr_i (redirect_addr),
        .stall_i         (stall_i),
        .rw_valid_o      (rw_valid),
        .rw_addr_o       (rw_addr),
        .rw_ready_i      (rw_ready),
        .beat_data_i     (beat_data),
        .instr_valid_o   (instr_valid_o),
        .instr_o         (instr_o),
        .pc_o            (pc_o),
        .deliver_o       (deliver)
    );

    axi_fetch_bridge axi_fetch_bridge_inst (
        .clock          (clock),
        .reset          (reset),
        .rw_valid_i     (rw_valid),
        .rw_addr_i      (rw_addr),
        .rw_ready_o     (rw_ready),
        .beat_data_o    (beat_data),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_o       (axi_ar_o),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_i        (axi_r_i),
        .axi_r_ready_o  (axi_r_ready_o)
    );

endmodule
